// File: hw/icache_arrays.sv
// -------------------------------------------------------------------------
// L1 instruction cache storage
// Tag and data memories per way plus valid flops. Synchronous set read,
// whole-line write, single-line invalidate and full flush.
// -------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module icache_arrays (
    input  logic          clk_i,
    input  logic          rst_n_i,
    icache_lookup_if.arrays lk
);
    import icache_geom_pkg::*;

    tag_t  tag_mem  [N_WAYS][N_SETS];
    line_t data_mem [N_WAYS][N_SETS];

    way_mask_t [N_SETS-1:0] valid_q;  // [set][way]

    // -------------------------------------------------------------------------
    // memories
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (lk.wr_en) begin
            tag_mem[lk.wr_way][lk.index]  <= lk.wr_tag;
            data_mem[lk.wr_way][lk.index] <= lk.wr_line;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lk.rd_en) begin
            for (int w = 0; w < N_WAYS; w++) begin
                lk.rd_tags[w]  <= tag_mem[w][lk.index];
                lk.rd_lines[w] <= data_mem[w][lk.index];
            end
        end
    end

    // -------------------------------------------------------------------------
    // valid bits
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (lk.flush_en) begin
            valid_q <= '0;                      // whole cache at once
        end else begin
            if (lk.wr_en) begin
                valid_q[lk.index][lk.wr_way] <= 1'b1;
            end
            if (lk.inv_en) begin
                valid_q[lk.index][lk.inv_way] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lk.rd_valid <= '0;
        end else if (lk.rd_en) begin
            lk.rd_valid <= valid_q[lk.index];   // same edge as tag/data read
        end
    end

    // a refill and an invalidation never overlap
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(lk.wr_en && lk.inv_en));

endmodule

`default_nettype wire

// File: hw/icache_ctrl.sv
// -------------------------------------------------------------------------
// L1 instruction cache controller
// Blocking FSM for fetch, miss/refill and line invalidation. Flush is
// handled in IDLE without leaving the state.
// -------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        req_valid_i,
    input  icache_geom_pkg::paddr_t     req_addr_i,
    input  logic                        inv_valid_i,
    input  icache_geom_pkg::paddr_t     inv_addr_i,
    input  logic                        hit_i,
    input  icache_geom_pkg::way_t       hit_way_i,
    input  icache_geom_pkg::way_t       victim_i,
    input  icache_geom_pkg::word_t      word_i,
    input  logic                        fill_req_ready_i,
    input  logic                        fill_resp_valid_i,
    input  icache_geom_pkg::line_t      fill_resp_data_i,
    icache_lookup_if.ctrl               lk,
    output icache_geom_pkg::tag_t       cmp_tag_o,
    output icache_geom_pkg::word_sel_t  word_sel_o,
    output logic                        advance_o,
    output logic                        resp_ready_o,
    output logic                        resp_valid_o,
    output icache_geom_pkg::word_t      resp_data_o,
    output icache_geom_pkg::paddr_t     resp_addr_o,
    output logic                        fill_req_valid_o,
    output icache_geom_pkg::paddr_t     fill_req_addr_o
);
    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    paddr_t      addr_q;        // fetch or invalidation address
    logic        is_inv_q;      // current pass is an invalidation
    way_t        victim_q;
    line_t       line_q;
    logic        resp_valid_q;
    word_t       resp_data_q;
    logic        take_inv;
    logic        take_req;
    logic        cmp_fetch;

    // flush > invalidation > request
    assign resp_ready_o = (state_q == IDLE) && !flush_i && !inv_valid_i;
    assign take_inv     = (state_q == IDLE) && !flush_i && inv_valid_i;
    assign take_req     = resp_ready_o && req_valid_i;
    assign cmp_fetch    = (state_q == COMPARE) && !is_inv_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (take_inv || take_req) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP:  state_d = COMPARE;
            COMPARE: state_d = (is_inv_q || hit_i) ? IDLE : FILL_REQ;
            FILL_REQ: begin
                if (fill_req_ready_i) begin
                    state_d = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                if (fill_resp_valid_i) begin
                    state_d = REFILL;
                end
            end
            REFILL:  state_d = LOOKUP;  // replay the fetch
            default: state_d = IDLE;
        endcase
    end

    // -------------------------------------------------------------------------
    // array commands
    // -------------------------------------------------------------------------
    assign cmp_tag_o   = addr_q[ADDR_BITS-1 -: TAG_BITS];
    assign word_sel_o  = addr_q[OFFSET_BITS-1 -: WSEL_BITS];
    assign lk.rd_en    = (state_q == LOOKUP);
    assign lk.index    = addr_q[OFFSET_BITS +: INDEX_BITS];
    assign lk.wr_en    = (state_q == REFILL);
    assign lk.wr_way   = victim_q;
    assign lk.wr_tag   = cmp_tag_o;
    assign lk.wr_line  = line_q;
    assign lk.inv_en   = (state_q == COMPARE) && is_inv_q && hit_i;
    assign lk.inv_way  = hit_way_i;
    assign lk.flush_en = (state_q == IDLE) && flush_i;

    // read data still holds the miss set during refill
    assign advance_o = lk.wr_en && (&lk.rd_valid);

    // -------------------------------------------------------------------------
    // registers
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= IDLE;
            is_inv_q     <= 1'b0;
            victim_q     <= '0;
            resp_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            resp_valid_q <= cmp_fetch && hit_i;
            if (take_inv || take_req) begin
                is_inv_q <= take_inv;
            end
            if (cmp_fetch && !hit_i) begin
                victim_q <= victim_i;   // way fixed at the miss
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_inv) begin
            addr_q <= inv_addr_i;
        end else if (take_req) begin
            addr_q <= req_addr_i;
        end
        if ((state_q == FILL_WAIT) && fill_resp_valid_i) begin
            line_q <= fill_resp_data_i;
        end
        if (cmp_fetch && hit_i) begin
            resp_data_q <= word_i;
        end
    end

    assign resp_valid_o     = resp_valid_q;
    assign resp_data_o      = resp_data_q;
    assign resp_addr_o      = addr_q;           // unchanged until next accept
    assign fill_req_valid_o = (state_q == FILL_REQ);
    assign fill_req_addr_o  = {addr_q[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    // posted fill request holds until the next level takes it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fill_req_valid_o && !fill_req_ready_i
        |=> fill_req_valid_o && $stable(fill_req_addr_o));

endmodule

`default_nettype wire

// File: hw/icache_ctrl_pkg.sv
// -------------------------------------------------------------------------
// L1 instruction cache controller phases
// -------------------------------------------------------------------------
`default_nettype none

package icache_ctrl_pkg;

    // one request or invalidation in flight at a time
    typedef enum logic [2:0] {
        IDLE,       // waiting, accepts flush, invalidation or fetch
        LOOKUP,     // index presented to the arrays
        COMPARE,    // tags checked against the read set
        FILL_REQ,   // line request posted to the next level
        FILL_WAIT,  // waiting for the returned line
        REFILL      // returned line written into the victim way
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: hw/icache_geom_pkg.sv
// -------------------------------------------------------------------------
// L1 instruction cache geometry
// 4 ways, 16 sets, 16-byte lines, 32-bit fetch words, physical addresses.
// Address layout is tag | index | word select | byte offset.
// -------------------------------------------------------------------------
`default_nettype none

package icache_geom_pkg;

    localparam int N_WAYS     = 4;
    localparam int N_SETS     = 16;
    localparam int LINE_BYTES = 16;
    localparam int WORD_BITS  = 32;
    localparam int ADDR_BITS  = 32;

    // derived widths
    localparam int LINE_BITS   = LINE_BYTES * 8;
    localparam int WAY_BITS    = $clog2(N_WAYS);
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int INDEX_BITS  = $clog2(N_SETS);
    localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int WSEL_BITS   = $clog2(LINE_BITS / WORD_BITS);  // words per line

    typedef logic [ADDR_BITS-1:0]  paddr_t;
    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [WSEL_BITS-1:0]  word_sel_t;
    typedef logic [LINE_BITS-1:0]  line_t;
    typedef logic [WORD_BITS-1:0]  word_t;
    typedef logic [WAY_BITS-1:0]   way_t;
    typedef logic [N_WAYS-1:0]     way_mask_t;  // one bit per way

endpackage

`default_nettype wire

// File: hw/icache_hit_check.sv
// -------------------------------------------------------------------------
// L1 instruction cache hit check
// Tag compare over all valid ways, word select from the hitting line.
// -------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module icache_hit_check (
    icache_lookup_if.check              lk,
    input  icache_geom_pkg::tag_t       cmp_tag_i,
    input  icache_geom_pkg::word_sel_t  word_sel_i,
    output logic                        hit_o,
    output icache_geom_pkg::way_t       hit_way_o,
    output icache_geom_pkg::word_t      word_o
);
    import icache_geom_pkg::*;

    way_mask_t way_hit;
    line_t     hit_line;

    always_comb begin
        for (int w = 0; w < N_WAYS; w++) begin
            way_hit[w] = lk.rd_valid[w] && (lk.rd_tags[w] == cmp_tag_i);
        end
    end

    // encode the hitting way, lowest way wins
    always_comb begin
        hit_way_o = '0;
        for (int w = N_WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                hit_way_o = way_t'(w);
            end
        end
    end

    assign hit_o    = |way_hit;
    assign hit_line = lk.rd_lines[hit_way_o];
    assign word_o   = hit_line[word_sel_i * WORD_BITS +: WORD_BITS];

    // a line lives in one way only, so refill and tag store agree
    assert property (@(posedge lk.clk_i)
        !$isunknown(way_hit) |-> $onehot0(way_hit));

endmodule

`default_nettype wire

// File: hw/icache_lookup_if.sv
// -------------------------------------------------------------------------
// L1 instruction cache array traffic
// Commands from the controller, read data back to hit check and replacement.
// -------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface icache_lookup_if (
    input logic clk_i
);
    import icache_geom_pkg::*;

    // commands
    logic   rd_en;
    index_t index;
    logic   wr_en;
    way_t   wr_way;
    tag_t   wr_tag;
    line_t  wr_line;
    logic   inv_en;
    way_t   inv_way;
    logic   flush_en;

    // registered read of the addressed set
    tag_t  [N_WAYS-1:0] rd_tags;
    way_mask_t          rd_valid;
    line_t [N_WAYS-1:0] rd_lines;

    modport ctrl (
        output rd_en, index, wr_en, wr_way, wr_tag, wr_line, inv_en, inv_way, flush_en,
        input  rd_valid
    );

    modport arrays (
        input  rd_en, index, wr_en, wr_way, wr_tag, wr_line, inv_en, inv_way, flush_en,
        output rd_tags, rd_valid, rd_lines
    );

    modport check (input clk_i, rd_tags, rd_valid, rd_lines);

    modport replace (input rd_valid);

endinterface

`default_nettype wire

// File: hw/icache_replace.sv
// -------------------------------------------------------------------------
// L1 instruction cache victim choice
// First invalid way of the read set, else the round-robin pointer.
// -------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module icache_replace (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    icache_lookup_if.replace        lk,
    input  logic                    advance_i,
    output icache_geom_pkg::way_t   victim_o
);
    import icache_geom_pkg::*;

    way_t rr_ptr_q;

    // scan from the top so the lowest invalid way is left standing
    always_comb begin
        victim_o = rr_ptr_q;
        for (int w = N_WAYS - 1; w >= 0; w--) begin
            if (!lk.rd_valid[w]) begin
                victim_o = way_t'(w);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rr_ptr_q <= '0;
        end else if (advance_i) begin
            rr_ptr_q <= rr_ptr_q + 1'b1;    // wraps at N_WAYS
        end
    end

endmodule

`default_nettype wire

// File: hw/icache_top.sv
// -------------------------------------------------------------------------
// L1 instruction cache top
// Blocking 4-way cache, 16 sets of 16-byte lines, one fetch at a time.
// Refills come from the next level, which may also invalidate lines.
// -------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module icache_top (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,

    // core side
    input  logic                        req_valid_i,
    input  icache_geom_pkg::paddr_t     req_addr_i,
    output logic                        resp_ready_o,
    output logic                        resp_valid_o,
    output icache_geom_pkg::word_t      resp_data_o,
    output icache_geom_pkg::paddr_t     resp_addr_o,

    // next level
    output logic                        fill_req_valid_o,
    input  logic                        fill_req_ready_i,
    output icache_geom_pkg::paddr_t     fill_req_addr_o,
    input  logic                        fill_resp_valid_i,
    input  icache_geom_pkg::line_t      fill_resp_data_i,

    // invalidation from the next level
    input  logic                        inv_valid_i,
    input  icache_geom_pkg::paddr_t     inv_addr_i
);
    import icache_geom_pkg::*;

    tag_t      cmp_tag;
    word_sel_t word_sel;
    logic      hit;
    way_t      hit_way;
    word_t     hit_word;
    way_t      victim;
    logic      advance;

    icache_lookup_if lk_if (
        .clk_i (clk_i)
    );

    icache_ctrl ctrl_i (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .req_valid_i       (req_valid_i),
        .req_addr_i        (req_addr_i),
        .inv_valid_i       (inv_valid_i),
        .inv_addr_i        (inv_addr_i),
        .hit_i             (hit),
        .hit_way_i         (hit_way),
        .victim_i          (victim),
        .word_i            (hit_word),
        .fill_req_ready_i  (fill_req_ready_i),
        .fill_resp_valid_i (fill_resp_valid_i),
        .fill_resp_data_i  (fill_resp_data_i),
        .lk                (lk_if.ctrl),
        .cmp_tag_o         (cmp_tag),
        .word_sel_o        (word_sel),
        .advance_o         (advance),
        .resp_ready_o      (resp_ready_o),
        .resp_valid_o      (resp_valid_o),
        .resp_data_o       (resp_data_o),
        .resp_addr_o       (resp_addr_o),
        .fill_req_valid_o  (fill_req_valid_o),
        .fill_req_addr_o   (fill_req_addr_o)
    );

    icache_arrays arrays_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .lk      (lk_if.arrays)
    );

    icache_hit_check hit_check_i (
        .lk         (lk_if.check),
        .cmp_tag_i  (cmp_tag),
        .word_sel_i (word_sel),
        .hit_o      (hit),
        .hit_way_o  (hit_way),
        .word_o     (hit_word)
    );

    icache_replace replace_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .lk        (lk_if.replace),
        .advance_i (advance),
        .victim_o  (victim)
    );

endmodule

`default_nettype wire

// File: sim.f
hw/icache_geom_pkg.sv
hw/icache_ctrl_pkg.sv
hw/icache_lookup_if.sv
hw/icache_arrays.sv
hw/icache_hit_check.sv
hw/icache_replace.sv
hw/icache_ctrl.sv
hw/icache_top.sv
test/icache_tb.sv

// File: test/icache_tb.sv
// ----------------------------------------------------------------------------
// L1 instruction cache testbench
// Drives fetches, invalidations and flushes into the cache top level, models
// the next level with random latency and tracks valid bits, tags and the
// round-robin pointer. Concurrent assertions compare the DUT's responses.
// ----------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module icache_tb;
    import icache_geom_pkg::*;

    localparam int WAIT_LIMIT = 100;    // cycles per wait loop

    typedef enum {NL_IDLE, NL_GRANT, NL_DATA} nl_phase_t;

    logic   clk_i;
    logic   rst_n_i;
    logic   flush_i;
    logic   req_valid_i;
    paddr_t req_addr_i;
    logic   resp_ready_o;
    logic   resp_valid_o;
    word_t  resp_data_o;
    paddr_t resp_addr_o;
    logic   fill_req_valid_o;
    logic   fill_req_ready_i;
    paddr_t fill_req_addr_o;
    logic   fill_resp_valid_i;
    line_t  fill_resp_data_i;
    logic   inv_valid_i;
    paddr_t inv_addr_i;

    logic   exp_hit;                    // model prediction for the pending fetch
    logic   accept;

    // reference model
    logic   model_valid [N_SETS][N_WAYS];
    tag_t   model_tag   [N_SETS][N_WAYS];
    int     model_rr;

    nl_phase_t   nl_phase;
    paddr_t      nl_addr;
    int          nl_count;
    logic [31:0] delay_seed;
    logic [31:0] stim_seed;

    icache_top dut_i (.*);

    always #4 clk_i = ~clk_i;

    assign accept = req_valid_i && resp_ready_o;

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // word w of the line at line_addr
    function automatic word_t expected_word(input paddr_t line_addr, input int w);
        logic [31:0] s;
        s = 32'd7 ^ (line_addr | (w << 2));
        s = lcg_step(lcg_step(s));
        return s;
    endfunction

    function automatic line_t line_pattern(input paddr_t line_addr);
        line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = expected_word(line_addr, w);
        end
        return l;
    endfunction

    function automatic logic model_hit(input paddr_t addr);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < N_WAYS; w++) begin
            if (model_valid[addr[7:4]][w] && model_tag[addr[7:4]][w] == addr[31:8]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // lowest invalid way, else the round-robin pointer
    task automatic model_fill(input paddr_t addr);
        int victim;
        victim = -1;
        for (int w = N_WAYS - 1; w >= 0; w--) begin
            if (!model_valid[addr[7:4]][w]) victim = w;
        end
        if (victim < 0) begin
            victim   = model_rr;
            model_rr = (model_rr + 1) % N_WAYS;
        end
        model_valid[addr[7:4]][victim] = 1'b1;
        model_tag[addr[7:4]][victim]   = addr[31:8];
    endtask

    task automatic model_flush();
        for (int s = 0; s < N_SETS; s++) begin
            for (int w = 0; w < N_WAYS; w++) model_valid[s][w] = 1'b0;
        end
    endtask

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic wait_for_ready(input string what);
        logic ready;
        ready = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !ready; n++) begin
            @(posedge clk_i);
            ready = resp_ready_o;
        end
        if (!ready) abort_run($sformatf("cache never became ready after %s", what));
    endtask

    task automatic fetch(input paddr_t addr);
        logic hit;
        logic flag;
        hit = model_hit(addr);
        req_valid_i <= 1'b1;
        req_addr_i  <= addr;
        exp_hit     <= hit;
        flag = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !flag; n++) begin
            @(posedge clk_i);
            flag = resp_ready_o;
        end
        req_valid_i <= 1'b0;
        if (!flag) abort_run($sformatf("fetch of %h was never accepted", addr));
        if (!hit) model_fill(addr);
        flag = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !flag; n++) begin
            @(posedge clk_i);
            flag = resp_valid_o;
        end
        if (!flag) abort_run($sformatf("no response for fetch of %h", addr));
    endtask

    task automatic invalidate(input paddr_t addr);
        inv_valid_i <= 1'b1;
        inv_addr_i  <= addr;
        @(posedge clk_i);
        inv_valid_i <= 1'b0;
        for (int w = 0; w < N_WAYS; w++) begin
            if (model_tag[addr[7:4]][w] == addr[31:8]) model_valid[addr[7:4]][w] = 1'b0;
        end
        wait_for_ready("an invalidation");
    endtask

    task automatic flush_all();
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        model_flush();
        wait_for_ready("a flush");
    endtask

    // ------------------------------------------------------------------------
    // next level, random grant and data latency
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            nl_phase <= NL_IDLE;
            nl_count <= 0;
        end else begin
            fill_req_ready_i  <= 1'b0;
            fill_resp_valid_i <= 1'b0;
            delay_seed = lcg_step(delay_seed);
            case (nl_phase)
                NL_IDLE: if (fill_req_valid_o) begin
                    nl_addr  <= fill_req_addr_o;
                    nl_count <= int'(delay_seed[17:16]);
                    nl_phase <= NL_GRANT;
                end
                NL_GRANT: if (nl_count == 0) begin
                    fill_req_ready_i <= 1'b1;
                    nl_count         <= 1 + int'(delay_seed[19:17]);
                    nl_phase         <= NL_DATA;
                end else begin
                    nl_count <= nl_count - 1;
                end
                NL_DATA: if (nl_count == 0) begin
                    fill_resp_valid_i <= 1'b1;
                    fill_resp_data_i  <= line_pattern(nl_addr);
                    nl_phase          <= NL_IDLE;
                end else begin
                    nl_count <= nl_count - 1;
                end
                default: nl_phase <= NL_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    assert property (@(posedge clk_i) $rose(rst_n_i)
        |-> !resp_valid_o && !fill_req_valid_o && resp_ready_o)
        else abort_run($sformatf("mismatch at %0t: outputs wrong after reset", $time));

    assert property (@(posedge clk_i) disable iff (!rst_n_i) accept && exp_hit
        |-> ##1 !resp_valid_o ##1 !resp_valid_o ##1 (resp_valid_o && !fill_req_valid_o))
        else abort_run($sformatf("mismatch at %0t: hit response timing", $time));

    assert property (@(posedge clk_i) disable iff (!rst_n_i) accept && !exp_hit
        |-> ##3 (fill_req_valid_o && !resp_valid_o))
        else abort_run($sformatf("mismatch at %0t: expected miss without fill request", $time));

    assert property (@(posedge clk_i) disable iff (!rst_n_i) fill_req_valid_o
        |-> fill_req_addr_o == (req_addr_i & ~32'hf))
        else abort_run($sformatf("mismatch at %0t: fill address %h", $time, fill_req_addr_o));

    assert property (@(posedge clk_i) disable iff (!rst_n_i) fill_resp_valid_i
        |-> ##1 !resp_valid_o ##1 !resp_valid_o ##1 !resp_valid_o ##1 resp_valid_o)
        else abort_run($sformatf("mismatch at %0t: refill response timing", $time));

    assert property (@(posedge clk_i) disable iff (!rst_n_i) resp_valid_o
        |-> resp_data_o == expected_word(req_addr_i & ~32'hf, int'(req_addr_i[3:2])))
        else abort_run($sformatf("mismatch at %0t: word %h for %h", $time, resp_data_o,
            req_addr_i));

    assert property (@(posedge clk_i) disable iff (!rst_n_i) resp_valid_o
        |-> resp_addr_o == req_addr_i)
        else abort_run($sformatf("mismatch at %0t: response address %h", $time, resp_addr_o));

    assert property (@(posedge clk_i) disable iff (!rst_n_i) inv_valid_i && !flush_i
        |-> !resp_ready_o ##1 !resp_ready_o ##1 !resp_ready_o ##1 resp_ready_o)
        else abort_run($sformatf("mismatch at %0t: ready during invalidation", $time));

    assert property (@(posedge clk_i) disable iff (!rst_n_i) flush_i
        |-> !resp_ready_o ##1 resp_ready_o)
        else abort_run($sformatf("mismatch at %0t: ready around flush", $time));

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        paddr_t cached [$];
        paddr_t addr;
        clk_i             = 1'b0;
        rst_n_i           = 1'b0;
        flush_i           = 1'b0;
        req_valid_i       = 1'b0;
        req_addr_i        = '0;
        fill_req_ready_i  = 1'b0;
        fill_resp_valid_i = 1'b0;
        fill_resp_data_i  = '0;
        inv_valid_i       = 1'b0;
        inv_addr_i        = '0;
        exp_hit           = 1'b0;
        delay_seed        = 32'd7;
        stim_seed         = 32'd7;
        model_rr          = 0;
        model_flush();
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);

        // first access, then hits on the same line
        fetch(32'h0000_0034);
        fetch(32'h0000_0038);
        fetch(32'h0000_003c);
        // fill set 3, a fifth line evicts
        fetch(32'h0000_0130);
        fetch(32'h0000_0234);
        fetch(32'h0000_0338);
        fetch(32'h0000_0430);
        fetch(32'h0000_0030);
        fetch(32'h0000_0234);
        fetch(32'h0000_0338);
        fetch(32'h0000_043c);
        // drop one line, neighbours stay
        invalidate(32'h0000_0230);
        fetch(32'h0000_0334);
        fetch(32'h0000_0430);
        fetch(32'h0000_0238);

        // random mix over two sets and six tags
        for (int i = 0; i < 24; i++) begin
            stim_seed = lcg_step(stim_seed);
            addr = (paddr_t'(stim_seed[18:16] % 6) << 8) | (paddr_t'(2 + stim_seed[20]) << 4)
                 | (paddr_t'(stim_seed[23:22]) << 2);
            fetch(addr);
        end

        for (int s = 0; s < N_SETS; s++) begin
            for (int w = 0; w < N_WAYS; w++) begin
                if (model_valid[s][w]) cached.push_back({model_tag[s][w], 4'(s), 4'h0});
            end
        end
        flush_all();
        foreach (cached[i]) fetch(cached[i] | 32'h4);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
